//--- Makefile
# Verilator build and run of the bus fabric testbench

TOP       ?= tb_bus_fabric
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
SEED      ?= 1

FILELIST  := verilog.f
SRCS      := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN       := obj_dir/V$(TOP)
PASS_MSG  := Simulation finished: PASS

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- addr_range_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module addr_range_decoder #(
    parameter logic [bus_pkg::ADDR_W-1:0] ADDR_BASE  = '0,
    parameter logic [bus_pkg::ADDR_W-1:0] ADDR_BOUND = '0
) (
    input  logic                       enable,
    input  logic [bus_pkg::ADDR_W-1:0] addr,
    output logic                       hit
);

    import bus_pkg::*;

    // the bound is inclusive so a region of one word has base equal to bound
    localparam int ADDR_COUNT = int'(ADDR_BOUND) - int'(ADDR_BASE) + 1;

    // ----------------------------------------------------------
    // one compare per address in the region
    // ----------------------------------------------------------

    logic [ADDR_COUNT-1:0] per_addr_match;

    // every address of the region gets its own equality test
    // address bits that run through all their values drop out during
    // synthesis, so an aligned power of two region ends up as a plain AND
    // of the fixed upper bits, and an unaligned one keeps only the terms
    // it really needs
    always_comb begin
        for (int i = 0; i < ADDR_COUNT; i++) begin
            per_addr_match[i] = (addr == ADDR_W'(int'(ADDR_BASE) + i));
        end
    end

    // ----------------------------------------------------------
    // combine the matches
    // ----------------------------------------------------------

    // a disabled region never claims an address, whatever it matches
    assign hit = enable & (|per_addr_match);

endmodule

`default_nettype wire

//--- bus_fabric_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric_top #(
    parameter logic [bus_pkg::ADDR_W-1:0] CTRL_BASE  = 16'h0000,
    parameter logic [bus_pkg::ADDR_W-1:0] CTRL_BOUND = 16'h000F,
    parameter logic [bus_pkg::ADDR_W-1:0] MEM0_BASE  = 16'h0100,
    parameter logic [bus_pkg::ADDR_W-1:0] MEM0_BOUND = 16'h013F,
    parameter logic [bus_pkg::ADDR_W-1:0] MEM1_BASE  = 16'h0140,
    parameter logic [bus_pkg::ADDR_W-1:0] MEM1_BOUND = 16'h01BF
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  bus_pkg::bus_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output bus_pkg::bus_rsp_t rsp
);

    import bus_pkg::*;

    // each RAM is exactly as deep as its region is long
    localparam int MEM0_DEPTH = int'(MEM0_BOUND) - int'(MEM0_BASE) + 1;
    localparam int MEM1_DEPTH = int'(MEM1_BOUND) - int'(MEM1_BASE) + 1;

    bus_req_t          slv_req;
    logic              ctrl_sel;
    logic              mem0_sel;
    logic              mem1_sel;
    logic              ctrl_rsp_valid;
    logic              mem0_rsp_valid;
    logic              mem1_rsp_valid;
    bus_rsp_t          ctrl_rsp;
    bus_rsp_t          mem0_rsp;
    bus_rsp_t          mem1_rsp;
    logic [NUM_MEM-1:0] mem_enable;
    logic              err_pulse;
    logic [ADDR_W-1:0] err_addr;

    // ----------------------------------------------------------
    // router between the master and the three slaves
    // ----------------------------------------------------------

    bus_router #(
        .CTRL_BASE (CTRL_BASE),
        .CTRL_BOUND(CTRL_BOUND),
        .MEM0_BASE (MEM0_BASE),
        .MEM0_BOUND(MEM0_BOUND),
        .MEM1_BASE (MEM1_BASE),
        .MEM1_BOUND(MEM1_BOUND)
    ) u_router (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp),
        .mem_enable    (mem_enable),
        .slv_req       (slv_req),
        .ctrl_sel      (ctrl_sel),
        .mem0_sel      (mem0_sel),
        .mem1_sel      (mem1_sel),
        .ctrl_rsp_valid(ctrl_rsp_valid),
        .mem0_rsp_valid(mem0_rsp_valid),
        .mem1_rsp_valid(mem1_rsp_valid),
        .ctrl_rsp      (ctrl_rsp),
        .mem0_rsp      (mem0_rsp),
        .mem1_rsp      (mem1_rsp),
        .err_pulse     (err_pulse),
        .err_addr      (err_addr)
    );

    // ----------------------------------------------------------
    // slaves
    // ----------------------------------------------------------

    // configuration block that also feeds the decoder enables
    ctrl_regs u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .sel       (ctrl_sel),
        .req       (slv_req),
        .rsp_valid (ctrl_rsp_valid),
        .rsp       (ctrl_rsp),
        .err_pulse (err_pulse),
        .err_addr  (err_addr),
        .mem_enable(mem_enable)
    );

    sram_slave #(
        .DEPTH    (MEM0_DEPTH),
        .ADDR_BASE(MEM0_BASE)
    ) u_mem0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .sel      (mem0_sel),
        .req      (slv_req),
        .rsp_valid(mem0_rsp_valid),
        .rsp      (mem0_rsp)
    );

    // mem1 starts right after mem0 and is not aligned to its own size
    sram_slave #(
        .DEPTH    (MEM1_DEPTH),
        .ADDR_BASE(MEM1_BASE)
    ) u_mem1 (
        .clk      (clk),
        .arst_n   (arst_n),
        .sel      (mem1_sel),
        .req      (slv_req),
        .rsp_valid(mem1_rsp_valid),
        .rsp      (mem1_rsp)
    );

endmodule

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none

// ----------------------------------------------------------
// shared widths and types of the bus fabric
// ----------------------------------------------------------

package bus_pkg;

    // addresses count words and not bytes
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // mem0 and mem1 are the regions that software may switch off
    localparam int NUM_MEM = 2;

    // a single bit is enough since the bus only reads and writes whole words
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // one request as the master issues it and as the router forwards it
    typedef struct packed {
        bus_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } bus_req_t;

    // err is only ever set by the router for an address that no region claims
    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        logic                err;
    } bus_rsp_t;

    // word offsets inside the configuration block
    // the offset field is 4 bits wide because the ctrl region spans 16 words
    typedef enum logic [3:0] {
        REG_ENABLE    = 4'd0,
        REG_ERR_COUNT = 4'd1,
        REG_ERR_ADDR  = 4'd2,
        REG_SCRATCH   = 4'd3
    } ctrl_reg_e;

endpackage

`default_nettype wire

//--- bus_router.sv
`timescale 1ns/1ps
`default_nettype none

module bus_router #(
    parameter logic [bus_pkg::ADDR_W-1:0] CTRL_BASE  = 16'h0000,
    parameter logic [bus_pkg::ADDR_W-1:0] CTRL_BOUND = 16'h000F,
    parameter logic [bus_pkg::ADDR_W-1:0] MEM0_BASE  = 16'h0100,
    parameter logic [bus_pkg::ADDR_W-1:0] MEM0_BOUND = 16'h013F,
    parameter logic [bus_pkg::ADDR_W-1:0] MEM1_BASE  = 16'h0140,
    parameter logic [bus_pkg::ADDR_W-1:0] MEM1_BOUND = 16'h01BF
) (
    input  logic                        clk,
    input  logic                        arst_n,
    // master request channel
    input  logic                        req_valid,
    output logic                        req_ready,
    input  bus_pkg::bus_req_t           req,
    // master response channel
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output bus_pkg::bus_rsp_t           rsp,
    // region enables from the configuration block
    input  logic [bus_pkg::NUM_MEM-1:0] mem_enable,
    // shared request and per slave selects
    output bus_pkg::bus_req_t           slv_req,
    output logic                        ctrl_sel,
    output logic                        mem0_sel,
    output logic                        mem1_sel,
    // slave answers, each one cycle after its select
    input  logic                        ctrl_rsp_valid,
    input  logic                        mem0_rsp_valid,
    input  logic                        mem1_rsp_valid,
    input  bus_pkg::bus_rsp_t           ctrl_rsp,
    input  bus_pkg::bus_rsp_t           mem0_rsp,
    input  bus_pkg::bus_rsp_t           mem1_rsp,
    // decode error report to the configuration block
    output logic                        err_pulse,
    output logic [bus_pkg::ADDR_W-1:0]  err_addr
);

    import bus_pkg::*;

    // only one transaction is in flight, so three states cover it
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_e;

    // one bit per slave region, in the same order everywhere
    typedef struct packed {
        logic ctrl;
        logic mem0;
        logic mem1;
    } route_t;

    state_e   state;
    route_t   hit;
    route_t   sel_q;
    logic     any_hit;
    logic     accept;
    logic     slv_rsp_valid;
    bus_rsp_t slv_rsp;

    // ----------------------------------------------------------
    // address decode of the incoming request
    // ----------------------------------------------------------

    // the ctrl region stays enabled so software can always undo a bad mask
    addr_range_decoder #(
        .ADDR_BASE (CTRL_BASE),
        .ADDR_BOUND(CTRL_BOUND)
    ) u_dec_ctrl (
        .enable(1'b1),
        .addr  (req.addr),
        .hit   (hit.ctrl)
    );

    addr_range_decoder #(
        .ADDR_BASE (MEM0_BASE),
        .ADDR_BOUND(MEM0_BOUND)
    ) u_dec_mem0 (
        .enable(mem_enable[0]),
        .addr  (req.addr),
        .hit   (hit.mem0)
    );

    addr_range_decoder #(
        .ADDR_BASE (MEM1_BASE),
        .ADDR_BOUND(MEM1_BOUND)
    ) u_dec_mem1 (
        .enable(mem_enable[1]),
        .addr  (req.addr),
        .hit   (hit.mem1)
    );

    assign any_hit   = |hit;
    assign req_ready = (state == ST_IDLE);
    assign accept    = req_valid & req_ready;

    // ----------------------------------------------------------
    // slave answer select
    // ----------------------------------------------------------

    // at most one slave answers per transaction so a priority mux is enough
    always_comb begin
        slv_rsp_valid = ctrl_rsp_valid | mem0_rsp_valid | mem1_rsp_valid;
        if (ctrl_rsp_valid) begin
            slv_rsp = ctrl_rsp;
        end else if (mem0_rsp_valid) begin
            slv_rsp = mem0_rsp;
        end else begin
            slv_rsp = mem1_rsp;
        end
    end

    // ----------------------------------------------------------
    // transaction FSM
    // ----------------------------------------------------------

    // selects and the error pulse are single cycle strobes by default
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            sel_q     <= '0;
            rsp_valid <= 1'b0;
            err_pulse <= 1'b0;
        end else begin
            sel_q     <= '0;
            err_pulse <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        if (any_hit) begin
                            // the registered hits become the select pulse
                            sel_q <= hit;
                            state <= ST_WAIT;
                        end else begin
                            // nobody claims the address so answer right away
                            rsp_valid <= 1'b1;
                            err_pulse <= 1'b1;
                            state     <= ST_RESP;
                        end
                    end
                end
                ST_WAIT: begin
                    if (slv_rsp_valid) begin
                        rsp_valid <= 1'b1;
                        state     <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // hold the answer until the master takes it
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // the forwarded request and the held answer
    always_ff @(posedge clk) begin
        if (accept) begin
            slv_req <= req;
        end
        if (accept && !any_hit) begin
            rsp <= '{rdata: '0, err: 1'b1};
        end else if (state == ST_WAIT && slv_rsp_valid) begin
            rsp <= slv_rsp;
        end
    end

    assign ctrl_sel = sel_q.ctrl;
    assign mem0_sel = sel_q.mem0;
    assign mem1_sel = sel_q.mem1;

    // the failing address is still in the request register while err_pulse is high
    assign err_addr = slv_req.addr;

endmodule

`default_nettype wire

//--- ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        sel,
    input  bus_pkg::bus_req_t           req,
    output logic                        rsp_valid,
    output bus_pkg::bus_rsp_t           rsp,
    input  logic                        err_pulse,
    input  logic [bus_pkg::ADDR_W-1:0]  err_addr,
    output logic [bus_pkg::NUM_MEM-1:0] mem_enable
);

    import bus_pkg::*;

    logic [DATA_W-1:0] err_count;
    logic [ADDR_W-1:0] err_addr_q;
    logic [DATA_W-1:0] scratch;
    logic [DATA_W-1:0] rd_data;
    logic              wr_en;
    ctrl_reg_e         offset;

    // the router already checked the region, so only the low bits matter here
    assign offset = ctrl_reg_e'(req.addr[3:0]);
    assign wr_en  = sel && (req.op == OP_WRITE);

    // ----------------------------------------------------------
    // read mux
    // ----------------------------------------------------------

    // offsets without a register read as zero
    always_comb begin
        case (offset)
            REG_ENABLE:    rd_data = DATA_W'(mem_enable);
            REG_ERR_COUNT: rd_data = err_count;
            REG_ERR_ADDR:  rd_data = DATA_W'(err_addr_q);
            REG_SCRATCH:   rd_data = scratch;
            default:       rd_data = '0;
        endcase
    end

    // ----------------------------------------------------------
    // control and status registers
    // ----------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_enable <= '1;
            err_count  <= '0;
            err_addr_q <= '0;
            rsp_valid  <= 1'b0;
        end else begin
            // the answer follows the select by exactly one cycle
            rsp_valid <= sel;

            if (wr_en && offset == REG_ENABLE) begin
                mem_enable <= req.wdata[NUM_MEM-1:0];
            end

            // a write of any value clears the count and beats a new error
            if (wr_en && offset == REG_ERR_COUNT) begin
                err_count <= '0;
            end else if (err_pulse && err_count != '1) begin
                err_count <= err_count + DATA_W'(1);
            end

            // only the most recent bad address is kept
            if (err_pulse) begin
                err_addr_q <= err_addr;
            end
        end
    end

    // scratch register and the registered answer to a select
    always_ff @(posedge clk) begin
        if (wr_en && offset == REG_SCRATCH) begin
            scratch <= req.wdata;
        end
        if (sel) begin
            // a write answers with zero data
            rsp.rdata <= wr_en ? '0 : rd_data;
            rsp.err   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sram_slave #(
    parameter int                         DEPTH     = 64,
    parameter logic [bus_pkg::ADDR_W-1:0] ADDR_BASE = '0
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              sel,
    input  bus_pkg::bus_req_t req,
    output logic              rsp_valid,
    output bus_pkg::bus_rsp_t rsp
);

    import bus_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]  idx;

    // the region need not be aligned so the base is subtracted first
    assign idx = IDX_W'(req.addr - ADDR_BASE);

    // ----------------------------------------------------------
    // storage and read port
    // ----------------------------------------------------------

    // the array comes up with whatever the RAM holds at power on
    always_ff @(posedge clk) begin
        if (sel) begin
            if (req.op == OP_WRITE) begin
                mem[idx]  <= req.wdata;
                rsp.rdata <= '0;
            end else begin
                rsp.rdata <= mem[idx];
            end
            rsp.err <= 1'b0;
        end
    end

    // answer valid is a one cycle echo of the select
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= sel;
        end
    end

endmodule

`default_nettype wire

//--- tb_bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_fabric;

    import bus_pkg::*;

    // address map as the fabric is meant to decode it
    localparam logic [ADDR_W-1:0] CTRL_BOUND = 16'h000F;
    localparam logic [ADDR_W-1:0] MEM0_BASE  = 16'h0100;
    localparam logic [ADDR_W-1:0] MEM0_BOUND = 16'h013F;
    localparam logic [ADDR_W-1:0] MEM1_BASE  = 16'h0140;
    localparam logic [ADDR_W-1:0] MEM1_BOUND = 16'h01BF;

    localparam logic [ADDR_W-1:0] EDGE_ADDRS [4] = '{16'h0100, 16'h013F, 16'h0140, 16'h01BF};
    localparam logic [ADDR_W-1:0] BAD_ADDRS  [4] = '{16'h0010, 16'h00FF, 16'h01C0, 16'hFFFF};

    // transactions of the test sequence below
    // each stays well below 20 cycles even with the longest stall
    localparam int NUM_RANDOM     = 24;
    localparam int NUM_TXN        = 2 + 2 * (4 + NUM_RANDOM) + 3 * 4 + 2 + 9;
    localparam int TIMEOUT_CYCLES = 20 * NUM_TXN + 200;

    logic     clk;
    logic     arst_n;
    logic     req_valid;
    logic     req_ready;
    bus_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    bus_rsp_t rsp;

    // reference model of everything software can observe
    logic [DATA_W-1:0]  mem_model [logic [ADDR_W-1:0]];
    logic [NUM_MEM-1:0] enable_model;
    logic [DATA_W-1:0]  err_count_model;
    logic [ADDR_W-1:0]  err_addr_model;
    logic [DATA_W-1:0]  scratch_model;
    logic [ADDR_W-1:0]  written_q [$];

    integer seed;
    int     cycle_count = 0;
    int     req_count = 0;
    int     rsp_count = 0;

    bus_fabric_top uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req      (req),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp      (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------
    // failure reporting
    // ----------------------------------------------------------

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] exp);
        stop_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // hangs show up as a run far longer than the test sequence needs
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("timeout: the test did not finish in %0d cycles", cycle_count));
        end
    end

    // both channels are counted so lost or doubled responses show at the end
    always @(posedge clk) begin
        if (arst_n && req_valid && req_ready) begin
            req_count <= req_count + 1;
        end
        if (arst_n && rsp_valid && rsp_ready) begin
            rsp_count <= rsp_count + 1;
        end
    end

    // ----------------------------------------------------------
    // handshake rules
    // ----------------------------------------------------------

    // a stalled response keeps both its valid and its payload
    assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else stop_run("response dropped or changed while rsp_ready was low");

    assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> !req_ready)
        else stop_run("req_ready was high while a response was pending");

    assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && rsp_ready |=> !rsp_valid)
        else stop_run("one request got a second response");

    assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && req_ready |=> !req_ready)
        else stop_run("req_ready stayed high after a request was accepted");

    // the fabric only opens again once the response has gone out
    assert property (@(posedge clk) disable iff (!arst_n)
        !req_ready && !(rsp_valid && rsp_ready) |=> !req_ready)
        else stop_run("req_ready returned before the response transfer");

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------

    function automatic bit is_decoded(input logic [ADDR_W-1:0] addr);
        if (addr <= CTRL_BOUND) begin
            return 1'b1;
        end
        if (addr >= MEM0_BASE && addr <= MEM0_BOUND) begin
            return enable_model[0];
        end
        if (addr >= MEM1_BASE && addr <= MEM1_BOUND) begin
            return enable_model[1];
        end
        return 1'b0;
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
        if (!is_decoded(addr)) begin
            return '0;
        end
        if (addr <= CTRL_BOUND) begin
            case (addr[3:0])
                4'd0:    return DATA_W'(enable_model);
                4'd1:    return err_count_model;
                4'd2:    return DATA_W'(err_addr_model);
                4'd3:    return scratch_model;
                default: return '0;
            endcase
        end
        return mem_model.exists(addr) ? mem_model[addr] : '0;
    endfunction

    task automatic update_model(input bus_op_e op, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata, input bit decoded);
        if (!decoded) begin
            if (err_count_model != '1) begin
                err_count_model = err_count_model + 1;
            end
            err_addr_model = addr;
        end else if (op == OP_WRITE) begin
            if (addr <= CTRL_BOUND) begin
                case (addr[3:0])
                    4'd0:    enable_model = wdata[NUM_MEM-1:0];
                    4'd1:    err_count_model = '0;
                    4'd3:    scratch_model = wdata;
                    default: ;
                endcase
            end else begin
                mem_model[addr] = wdata;
            end
        end
    endtask

    // ----------------------------------------------------------
    // bus transactions
    // ----------------------------------------------------------

    // one full request and response with a random stall on the response side
    task automatic transact(input bus_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata);
        bus_rsp_t          got;
        int                accept_cycle;
        int                latency;
        int                stall;
        bit                decoded;
        bit                seen;
        logic [DATA_W-1:0] exp_rdata;
        decoded   = is_decoded(addr);
        exp_rdata = (op == OP_WRITE) ? '0 : expected_read(addr);
        stall     = $unsigned($random(seed)) % 8;
        seen      = 1'b0;
        latency   = 0;
        got       = '0;
        req_valid <= 1'b1;
        req       <= '{op: op, addr: addr, wdata: wdata};
        rsp_ready <= (stall == 0);
        do begin
            @(posedge clk);
        end while (!req_ready);
        accept_cycle = cycle_count;
        req_valid <= 1'b0;
        while (1'b1) begin
            @(posedge clk);
            if (rsp_valid && !seen) begin
                seen    = 1'b1;
                latency = cycle_count - accept_cycle;
                got     = rsp;
            end
            if (rsp_valid && rsp_ready) begin
                break;
            end
            if (rsp_valid) begin
                stall = stall - 1;
                if (stall == 0) begin
                    rsp_ready <= 1'b1;
                end
            end
        end
        // three cycles through a slave and one for an error answered by the router
        assert (latency == (decoded ? 3 : 1))
            else report_mismatch("latency", DATA_W'(latency), decoded ? 3 : 1);
        assert (got.err == !decoded)
            else report_mismatch("rsp.err", DATA_W'(got.err), DATA_W'(!decoded));
        assert (got.rdata == exp_rdata)
            else report_mismatch($sformatf("rsp.rdata @0x%h", addr), got.rdata, exp_rdata);
        update_model(op, addr, wdata, decoded);
    endtask

    task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        transact(OP_WRITE, addr, data);
    endtask

    task automatic do_read(input logic [ADDR_W-1:0] addr);
        transact(OP_READ, addr, '0);
    endtask

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------

    initial begin
        logic [ADDR_W-1:0] addr;
        seed            = 32'h2dcb5f5f;
        arst_n          = 1'b0;
        req_valid       = 1'b0;
        req             = '0;
        rsp_ready       = 1'b0;
        enable_model    = '1;
        err_count_model = '0;
        err_addr_model  = '0;
        scratch_model   = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        assert (req_ready == 1'b1) else report_mismatch("req_ready", DATA_W'(req_ready), 1);
        assert (rsp_valid == 1'b0) else report_mismatch("rsp_valid", DATA_W'(rsp_valid), 0);
        do_read(ADDR_W'(REG_ENABLE));
        do_read(ADDR_W'(REG_ERR_COUNT));

        // region edges first and then random words over both RAMs
        foreach (EDGE_ADDRS[i]) begin
            do_write(EDGE_ADDRS[i], $random(seed));
            written_q.push_back(EDGE_ADDRS[i]);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            addr = MEM0_BASE + ADDR_W'($unsigned($random(seed)) % 192);
            do_write(addr, $random(seed));
            written_q.push_back(addr);
        end
        // reading every word back also catches aliasing between mem0 and mem1
        foreach (written_q[i]) begin
            do_read(written_q[i]);
        end

        // each unmapped address is followed by a look at the error log
        foreach (BAD_ADDRS[i]) begin
            if (i % 2 == 1) begin
                do_write(BAD_ADDRS[i], $random(seed));
            end else begin
                do_read(BAD_ADDRS[i]);
            end
            do_read(ADDR_W'(REG_ERR_COUNT));
            do_read(ADDR_W'(REG_ERR_ADDR));
        end
        do_write(ADDR_W'(REG_ERR_COUNT), $random(seed));
        do_read(ADDR_W'(REG_ERR_COUNT));

        // switch mem1 off and back on and make sure its old contents survive
        do_write(ADDR_W'(REG_ENABLE), 32'd1);
        do_write(MEM1_BOUND, $random(seed));
        do_read(MEM1_BASE);
        do_read(ADDR_W'(REG_ERR_COUNT));
        do_write(ADDR_W'(REG_ENABLE), 32'd3);
        do_read(MEM1_BASE);
        do_read(MEM1_BOUND);
        do_write(ADDR_W'(REG_SCRATCH), $random(seed));
        do_read(ADDR_W'(REG_SCRATCH));

        @(posedge clk);
        if (req_count == rsp_count) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_run($sformatf("%0d requests were accepted but %0d responses came back",
                               req_count, rsp_count));
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
bus_pkg.sv
addr_range_decoder.sv
ctrl_regs.sv
sram_slave.sv
bus_router.sv
bus_fabric_top.sv
tb_bus_fabric.sv
